//--- flist.f
+incdir+tests
design/soc_pkg.sv
design/soc_addr_decoder.sv
design/soc_sram_bank.sv
design/soc_gpio_regs.sv
design/soc_resp_mux.sv
design/soc_bus_top.sv
tests/soc_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - files:
      - design/soc_pkg.sv
      - design/soc_addr_decoder.sv
      - design/soc_sram_bank.sv
      - design/soc_gpio_regs.sv
      - design/soc_resp_mux.sv
      - design/soc_bus_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/soc_tb.sv

//--- tests/soc_tb_tasks.svh
`ifndef SOC_TB_TASKS_SVH
`define SOC_TB_TASKS_SVH

// Reference model of RAM and GPIO output
logic [DATA_W-1:0]     ram_model [RAM_WORDS];
logic [GPIO_OUT_W-1:0] gpio_model;
logic [31:0]           rng_state;

// Response due in the next cycle
logic              exp_valid;
logic              exp_err;
logic [DATA_W-1:0] exp_rdata;
logic [ADDR_W-1:0] exp_addr;

function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic logic [ADDR_W-1:0] ram_word_addr(input int unsigned word_num);
  return {RAM_REGION, 28'h000_0000} + ADDR_W'(word_num) * 4;
endfunction

function automatic logic [ADDR_W-1:0] gpio_reg_addr(input logic [GPIO_OFS_W-1:0] ofs);
  return GPIO_BASE + (ADDR_W'(ofs) << 2);
endfunction

task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
  if (actual !== expected) begin
    $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    $display("Simulation failed");
    $fatal(1, "Value mismatch");
  end
endtask

// Checks the previous response, then presents the next request
task automatic drive_cycle(input logic valid, input logic write,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
  int unsigned word_num;
  @(posedge core_clk);
  #DRIVE_DLY;
  check_eq(bus_rsp.valid, exp_valid, $sformatf("valid for %h", exp_addr));
  if (exp_valid) begin
    check_eq(bus_rsp.err, exp_err, $sformatf("err for %h", exp_addr));
    check_eq(bus_rsp.rdata, exp_rdata, $sformatf("rdata for %h", exp_addr));
  end
  check_eq(gpio_out, gpio_model, "gpio_out_o");

  bus_req.valid    = valid;
  bus_req.write    = write;
  bus_req.addr.raw = addr;
  bus_req.wdata    = wdata;

  exp_valid = valid;
  exp_err   = 1'b0;
  exp_rdata = '0;
  exp_addr  = addr;
  word_num  = addr[27:2];
  if (valid) begin
    if ((addr[31:28] == RAM_REGION) && (word_num < RAM_WORDS)) begin
      if (write) ram_model[word_num] = wdata;
      else exp_rdata = ram_model[word_num];
    end else if ((addr >= GPIO_BASE) && (addr < GPIO_BASE + 32'd16)) begin
      if (write && (addr[3:2] == GPIO_OUT_OFS)) gpio_model = wdata[GPIO_OUT_W-1:0];
      else if (!write && (addr[3:2] == GPIO_OUT_OFS)) exp_rdata = DATA_W'(gpio_model);
      else if (!write && (addr[3:2] == GPIO_IN_OFS)) exp_rdata = DATA_W'(gpio_in);
    end else begin
      exp_err = 1'b1;
    end
  end
endtask

task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
  drive_cycle(1'b1, 1'b1, addr, data);
endtask

task automatic read_word(input logic [ADDR_W-1:0] addr);
  drive_cycle(1'b1, 1'b0, addr, '0);
endtask

task automatic idle_cycle();
  drive_cycle(1'b0, 1'b0, '0, '0);
endtask

task automatic reset_state_values();
  check_eq(bus_rsp.valid, 1'b0, "valid after reset");
  check_eq(gpio_out, '0, "gpio_out_o after reset");
endtask

task automatic ram_write_readback();
  int unsigned picks [3];
  picks = '{0, BANK_WORDS / 2, BANK_WORDS - 1};
  for (int b = 0; b < NUM_BANKS; b++) begin
    for (int i = 0; i < 3; i++) write_word(ram_word_addr(b * BANK_WORDS + picks[i]), next_random());
  end
  for (int b = 0; b < NUM_BANKS; b++) begin
    for (int i = 0; i < 3; i++) read_word(ram_word_addr(b * BANK_WORDS + picks[i]));
  end
  idle_cycle();
endtask

task automatic stream_reads();
  int unsigned w;
  for (int i = 0; i < RAM_WORDS; i++) write_word(ram_word_addr(i), next_random());
  // Banks alternate on every read
  for (int i = 0; i < BANK_WORDS; i++) begin
    for (int b = 0; b < NUM_BANKS; b++) read_word(ram_word_addr(b * BANK_WORDS + i));
  end
  for (int i = 0; i < RAM_WORDS; i++) read_word(ram_word_addr(next_random() % RAM_WORDS));
  // Read right behind a write to the same word
  for (int i = 0; i < 32; i++) begin
    w = next_random() % RAM_WORDS;
    write_word(ram_word_addr(w), next_random());
    read_word(ram_word_addr(w));
  end
  idle_cycle();
endtask

task automatic gpio_access();
  write_word(gpio_reg_addr(GPIO_OUT_OFS), next_random());
  read_word(gpio_reg_addr(GPIO_OUT_OFS));
  gpio_in = 4'ha;
  read_word(gpio_reg_addr(GPIO_IN_OFS));
  // Input pattern is sampled at the request edge
  idle_cycle();
  gpio_in = 4'h5;
  read_word(gpio_reg_addr(GPIO_IN_OFS));
  write_word(gpio_reg_addr(GPIO_IN_OFS), next_random());
  read_word(gpio_reg_addr(GPIO_OUT_OFS));
  read_word(gpio_reg_addr(GPIO_IN_OFS));
  idle_cycle();
endtask

task automatic unmapped_access();
  write_word(32'h3000_0000, next_random());
  read_word(32'h3000_0000);
  write_word(32'h0000_0100, next_random());
  write_word(ram_word_addr(RAM_WORDS), next_random());
  read_word(ram_word_addr(RAM_WORDS));
  write_word(ram_word_addr(RAM_WORDS + BANK_WORDS), next_random());
  write_word(GPIO_BASE + 32'h10, next_random());
  read_word(GPIO_BASE + 32'h10);
  // Locations the rejected addresses alias onto
  read_word(ram_word_addr(0));
  read_word(ram_word_addr(BANK_WORDS));
  read_word(gpio_reg_addr(GPIO_OUT_OFS));
  idle_cycle();
endtask

`endif

//--- tests/soc_tb.sv
`timescale 1ns/1ns

module soc_tb;
  import soc_pkg::*;

  localparam int NUM_BANKS  = 2;
  localparam int BANK_WORDS = 64;
  localparam int RAM_WORDS  = NUM_BANKS * BANK_WORDS;

  localparam int CLK_HALF  = 2;
  localparam int DRIVE_DLY = 1;

  // Tests take roughly 600 cycles
  localparam int MAX_CYCLES = 2000;

  localparam logic [31:0] SEED = 32'hf97cefe1;

  logic                  core_clk;
  logic                  reset_n;
  bus_req_t              bus_req;
  logic [GPIO_IN_W-1:0]  gpio_in;
  bus_rsp_t              bus_rsp;
  logic [GPIO_OUT_W-1:0] gpio_out;

  int unsigned cycle_cnt = 0;

  soc_bus_top #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS)
  ) u_dut (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .bus_req_i  (bus_req),
    .gpio_in_i  (gpio_in),
    .bus_rsp_o  (bus_rsp),
    .gpio_out_o (gpio_out)
  );

  initial begin
    core_clk = 1'b0;
    forever #CLK_HALF core_clk = ~core_clk;
  end

  always @(posedge core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the simulation timed out after %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end
  end

  `include "soc_tb_tasks.svh"

  initial begin
    reset_n    = 1'b0;
    bus_req    = '0;
    gpio_in    = '0;
    rng_state  = SEED;
    gpio_model = '0;
    exp_valid  = 1'b0;
    exp_err    = 1'b0;
    exp_rdata  = '0;
    exp_addr   = '0;

    // GPIO write held during reset must be ignored
    bus_req.valid    = 1'b1;
    bus_req.write    = 1'b1;
    bus_req.addr.raw = GPIO_BASE;
    bus_req.wdata    = '1;

    repeat (2) @(posedge core_clk);
    #DRIVE_DLY;
    reset_n = 1'b1;
    bus_req = '0;

    reset_state_values();
    ram_write_readback();
    stream_reads();
    gpio_access();
    unmapped_access();

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- design/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 64
) (
  input  logic                           core_clk,
  input  logic                           reset_n,
  input  soc_pkg::bus_req_t              bus_req_i,
  input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_in_i,
  output soc_pkg::bus_rsp_t              bus_rsp_o,
  output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_out_o
);
  import soc_pkg::*;

  localparam int IDX_W = $clog2(BANK_WORDS);

  logic [NUM_BANKS-1:0]        bank_sel;
  logic                        gpio_sel;
  logic                        write;
  logic [IDX_W-1:0]            word_idx;
  logic [GPIO_OFS_W-1:0]       gpio_ofs;
  logic [DATA_W-1:0]           wdata;
  logic [NUM_BANKS:0]          rsp_sel;
  logic                        rsp_pending;
  logic                        rsp_unmapped;
  logic                        rsp_write;
  logic [NUM_BANKS*DATA_W-1:0] bank_rdata;
  logic [DATA_W-1:0]           gpio_rdata;

  soc_addr_decoder #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS)
  ) u_decoder (
    .core_clk       (core_clk),
    .reset_n        (reset_n),
    .req_i          (bus_req_i),
    .bank_sel_o     (bank_sel),
    .gpio_sel_o     (gpio_sel),
    .write_o        (write),
    .word_idx_o     (word_idx),
    .gpio_ofs_o     (gpio_ofs),
    .wdata_o        (wdata),
    .rsp_sel_o      (rsp_sel),
    .rsp_pending_o  (rsp_pending),
    .rsp_unmapped_o (rsp_unmapped),
    .rsp_write_o    (rsp_write)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    soc_sram_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) u_bank (
      .core_clk   (core_clk),
      .sel_i      (bank_sel[k]),
      .write_i    (write),
      .word_idx_i (word_idx),
      .wdata_i    (wdata),
      .rdata_o    (bank_rdata[k*DATA_W +: DATA_W])
    );
  end

  soc_gpio_regs u_gpio (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .sel_i      (gpio_sel),
    .write_i    (write),
    .ofs_i      (gpio_ofs),
    .wdata_i    (wdata),
    .gpio_in_i  (gpio_in_i),
    .rdata_o    (gpio_rdata),
    .gpio_out_o (gpio_out_o)
  );

  soc_resp_mux #(
    .NUM_BANKS (NUM_BANKS)
  ) u_resp_mux (
    .rsp_sel_i      (rsp_sel),
    .rsp_pending_i  (rsp_pending),
    .rsp_unmapped_i (rsp_unmapped),
    .rsp_write_i    (rsp_write),
    .bank_rdata_i   (bank_rdata),
    .gpio_rdata_i   (gpio_rdata),
    .rsp_o          (bus_rsp_o)
  );

endmodule

//--- design/soc_resp_mux.sv
`timescale 1ns/1ns

module soc_resp_mux #(
  parameter int NUM_BANKS = 2
) (
  input  logic [NUM_BANKS:0]                   rsp_sel_i,
  input  logic                                 rsp_pending_i,
  input  logic                                 rsp_unmapped_i,
  input  logic                                 rsp_write_i,
  input  logic [NUM_BANKS*soc_pkg::DATA_W-1:0] bank_rdata_i,
  input  logic [soc_pkg::DATA_W-1:0]           gpio_rdata_i,
  output soc_pkg::bus_rsp_t                    rsp_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] rdata;

  // Unselected slaves may hold stale or unknown data
  always_comb begin
    rdata = '0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      if (rsp_sel_i[k]) begin
        rdata = bank_rdata_i[k*DATA_W +: DATA_W];
      end
    end
    if (rsp_sel_i[NUM_BANKS]) begin
      rdata = gpio_rdata_i;
    end
    if (rsp_write_i || rsp_unmapped_i) begin
      rdata = '0;
    end
  end

  always_comb begin
    rsp_o.valid = rsp_pending_i;
    rsp_o.err   = rsp_pending_i && rsp_unmapped_i;
    rsp_o.rdata = rdata;
  end

  // A good response must come from exactly one slave
  always_comb begin
    if (rsp_o.valid && !rsp_o.err) begin
      a_rsp_sel_onehot: assert ($onehot(rsp_sel_i));
    end
  end

endmodule

//--- design/soc_gpio_regs.sv
`timescale 1ns/1ns

module soc_gpio_regs (
  input  logic                           core_clk,
  input  logic                           reset_n,
  input  logic                           sel_i,
  input  logic                           write_i,
  input  logic [soc_pkg::GPIO_OFS_W-1:0] ofs_i,
  input  logic [soc_pkg::DATA_W-1:0]     wdata_i,
  input  logic [soc_pkg::GPIO_IN_W-1:0]  gpio_in_i,
  output logic [soc_pkg::DATA_W-1:0]     rdata_o,
  output logic [soc_pkg::GPIO_OUT_W-1:0] gpio_out_o
);
  import soc_pkg::*;

  logic [GPIO_OUT_W-1:0] gpio_out_q;
  logic [DATA_W-1:0]     rdata_q;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      gpio_out_q <= '0;
    end else if (sel_i && write_i && (ofs_i == GPIO_OUT_OFS)) begin
      gpio_out_q <= wdata_i[GPIO_OUT_W-1:0];
    end
  end

  // Readback, spare window offsets read as zero
  always_ff @(posedge core_clk) begin
    if (sel_i && !write_i) begin
      case (ofs_i)
        GPIO_OUT_OFS: rdata_q <= DATA_W'(gpio_out_q);
        GPIO_IN_OFS:  rdata_q <= DATA_W'(gpio_in_i);
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o    = rdata_q;
  assign gpio_out_o = gpio_out_q;

endmodule

//--- design/soc_sram_bank.sv
`timescale 1ns/1ns

module soc_sram_bank #(
  parameter int BANK_WORDS = 64
) (
  input  logic                          core_clk,
  input  logic                          sel_i,
  input  logic                          write_i,
  input  logic [$clog2(BANK_WORDS)-1:0] word_idx_i,
  input  logic [soc_pkg::DATA_W-1:0]    wdata_i,
  output logic [soc_pkg::DATA_W-1:0]    rdata_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] mem [BANK_WORDS];
  logic [DATA_W-1:0] rdata_q;

  // Single port, a write does not update the read register
  always_ff @(posedge core_clk) begin
    if (sel_i) begin
      if (write_i) begin
        mem[word_idx_i] <= wdata_i;
      end else begin
        rdata_q <= mem[word_idx_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- design/soc_addr_decoder.sv
`timescale 1ns/1ns

module soc_addr_decoder #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 64
) (
  input  logic                             core_clk,
  input  logic                             reset_n,
  input  soc_pkg::bus_req_t                req_i,
  output logic [NUM_BANKS-1:0]             bank_sel_o,
  output logic                             gpio_sel_o,
  output logic                             write_o,
  output logic [$clog2(BANK_WORDS)-1:0]    word_idx_o,
  output logic [soc_pkg::GPIO_OFS_W-1:0]   gpio_ofs_o,
  output logic [soc_pkg::DATA_W-1:0]       wdata_o,
  output logic [NUM_BANKS:0]               rsp_sel_o,
  output logic                             rsp_pending_o,
  output logic                             rsp_unmapped_o,
  output logic                             rsp_write_o
);
  import soc_pkg::*;

  localparam int IDX_W     = $clog2(BANK_WORDS);
  localparam int RAM_WORDS = NUM_BANKS * BANK_WORDS;

  logic [27:2]      word_addr;
  logic [27:2]      bank_num;
  logic             ram_hit;
  logic             gpio_hit;
  logic [NUM_BANKS:0] sel;

  // Low two address bits are ignored, word accesses only
  assign word_addr = req_i.addr.fields.offset[27:2];
  assign bank_num  = word_addr >> IDX_W;

  assign ram_hit  = req_i.valid && (req_i.addr.fields.region == RAM_REGION) &&
                    (word_addr < 26'(RAM_WORDS));
  assign gpio_hit = req_i.valid && ((req_i.addr.raw & GPIO_SPAN_MASK) == GPIO_BASE);

  always_comb begin
    sel = '0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      sel[k] = ram_hit && (bank_num == 26'(k));
    end
    sel[NUM_BANKS] = gpio_hit;
  end

  assign bank_sel_o = sel[NUM_BANKS-1:0];
  assign gpio_sel_o = sel[NUM_BANKS];
  assign write_o    = req_i.write;
  assign word_idx_o = word_addr[IDX_W+1:2];
  assign gpio_ofs_o = req_i.addr.fields.offset[3:2];
  assign wdata_o    = req_i.wdata;

  // Response record, answered one cycle later
  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      rsp_sel_o      <= '0;
      rsp_pending_o  <= 1'b0;
      rsp_unmapped_o <= 1'b0;
      rsp_write_o    <= 1'b0;
    end else begin
      rsp_sel_o      <= sel;
      rsp_pending_o  <= req_i.valid;
      rsp_unmapped_o <= req_i.valid && !(|sel);
      rsp_write_o    <= req_i.valid && req_i.write;
    end
  end

  a_sel_onehot0: assert property (@(posedge core_clk) disable iff (!reset_n) $onehot0(sel));

endmodule

//--- design/soc_pkg.sv
package soc_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int GPIO_OUT_W = 12;
  localparam int GPIO_IN_W  = 4;

  // Word offset width inside the GPIO window
  localparam int GPIO_OFS_W = 2;

  localparam logic [3:0] RAM_REGION  = 4'd2;
  localparam logic [3:0] GPIO_REGION = 4'd4;

  localparam logic [GPIO_OFS_W-1:0] GPIO_OUT_OFS = 2'd0;
  localparam logic [GPIO_OFS_W-1:0] GPIO_IN_OFS  = 2'd1;

  localparam logic [ADDR_W-1:0] GPIO_BASE      = {GPIO_REGION, 28'h000_0000};
  localparam logic [ADDR_W-1:0] GPIO_END       = GPIO_BASE + 32'h0000_000f;
  localparam logic [ADDR_W-1:0] GPIO_SPAN_MASK = ~(GPIO_END - GPIO_BASE);

  typedef struct packed {
    logic [3:0]  region;
    logic [27:0] offset;
  } bus_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    bus_addr_fields_t  fields;
  } bus_addr_u;

  typedef struct packed {
    logic              valid;
    logic              write;
    bus_addr_u         addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage
